//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = controlUnitTb
FILELIST = files.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/cuPkg.sv
package cuPkg;

	// instruction register layout
	localparam int irWidth = 32;
	localparam int classLsb = 25;
	localparam int classMsb = 27;
	localparam int classWidth = classMsb - classLsb + 1;
	localparam int linkBit = 20;

	localparam int stateWidth = 7;
	localparam int aluOpWidth = 5;

	// memory transfer size, word access only in the kept states
	localparam logic [1:0] memSizeWord = 2'b10;

	// alu operation codes used by the microcode
	localparam logic [aluOpWidth-1:0] aluPass = 5'b10000;
	localparam logic [aluOpWidth-1:0] aluPassInc = 5'b10001;
	localparam logic [aluOpWidth-1:0] aluAdd = 5'b10011;
	localparam logic [aluOpWidth-1:0] aluMovB = 5'b00100;

	// shifter modes
	localparam logic [2:0] shiftRotImm = 3'b001;
	localparam logic [2:0] shiftBranchOff = 3'b100;

	// microcode states, numbered as in the original sequencer
	typedef enum logic [stateWidth-1:0]
	{
		reset = 7'd0,
		fetch1 = 7'd1,
		fetch2 = 7'd2,
		fetchWait = 7'd3,
		decode = 7'd4,
		dpImm1 = 7'd5,
		dpImm2 = 7'd6,
		dpShift = 7'd7,
		branch1 = 7'd8,
		branch2 = 7'd9,
		branchLink = 7'd10
	} stateCode_t;

	// opcode class in ir[27:25]
	typedef enum logic [classWidth-1:0]
	{
		dataShifter = 3'd0,
		dataImmediate = 3'd1,
		loadStoreImm = 3'd2,
		loadStoreReg = 3'd3,
		branch = 3'd5
	} instrClass_t;

	// datapath multiplexer selects
	typedef struct packed
	{
		logic [1:0] muxA;
		logic [1:0] muxB;
		logic [2:0] muxC;
		logic muxD;
		logic [1:0] muxF;
		logic muxH;
		logic [1:0] muxJ;
	} muxSel_t;

	typedef struct packed
	{
		logic clear;
		logic regFileLoad;
		logic irLoad;
		logic marLoad;
		logic memReadWrite;
		logic memEnable;
		logic [1:0] memSize;
		logic flagLoad;
		muxSel_t sel;
		logic shiftEnable;
		logic [2:0] shiftType;
		logic [aluOpWidth-1:0] aluOp;
	} ctrlWord_t;

	typedef struct packed
	{
		instrClass_t instrClass;
		logic isDataImm;
		logic isDataShift;
		logic isBranch;
		logic withLink;
	} decodedInstr_t;

	localparam ctrlWord_t idleWord = '0;
	localparam ctrlWord_t resetWord = '{clear: 1'b1, default: '0};

endpackage

//--- files.f
common/cuPkg.sv
sequencer/instrDecoder.sv
sequencer/nextStateLogic.sv
verilog/microcodeRom.sv
verilog/controlUnit.sv
tb/controlUnit_properties.sv
tb/controlUnitTb.sv

//--- sequencer/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder
(
	input logic [cuPkg::irWidth-1:0] ir,
	output cuPkg::decodedInstr_t decoded
);

	cuPkg::instrClass_t opClass;
	logic linkSel;

	assign opClass = cuPkg::instrClass_t'(ir[cuPkg::classMsb:cuPkg::classLsb]);
	assign linkSel = ir[cuPkg::linkBit];

	always_comb
	begin
		decoded = '0;
		decoded.instrClass = opClass;
		case (opClass)
			cuPkg::dataImmediate:
			begin
				decoded.isDataImm = 1'b1;
			end
			cuPkg::dataShifter:
			begin
				decoded.isDataShift = 1'b1;
			end
			cuPkg::branch:
			begin
				decoded.isBranch = 1'b1;
				// link bit only has a meaning for branches
				decoded.withLink = linkSel;
			end
			default:
			begin
				// load/store and reserved classes leave every flag clear
			end
		endcase
	end

endmodule

//--- sequencer/nextStateLogic.sv
`timescale 1ns/1ps

module nextStateLogic
(
	input logic CLK,
	input logic rstN,
	input logic cond,
	input logic moc,
	input cuPkg::decodedInstr_t decoded,
	output cuPkg::stateCode_t state
);

	cuPkg::stateCode_t nextState;
	cuPkg::stateCode_t dispatchState;

	// first step of the instruction once decode has passed the condition
	always_comb
	begin
		if (decoded.isDataImm)
		begin
			dispatchState = cuPkg::dpImm1;
		end
		else if (decoded.isDataShift)
		begin
			dispatchState = cuPkg::dpShift;
		end
		else if (decoded.isBranch)
		begin
			// with link the return address is saved before the branch proper
			dispatchState = decoded.withLink ? cuPkg::branchLink : cuPkg::branch1;
		end
		else
		begin
			dispatchState = cuPkg::fetch1;
		end
	end

	always_comb
	begin
		case (state)
			cuPkg::reset:
				nextState = cuPkg::fetch1;
			cuPkg::fetch1:
				nextState = cuPkg::fetch2;
			cuPkg::fetch2:
				nextState = cuPkg::fetchWait;
			cuPkg::fetchWait:
				// hold until memory signals completion
				nextState = moc ? cuPkg::decode : cuPkg::fetchWait;
			cuPkg::decode:
				nextState = cond ? dispatchState : cuPkg::fetch1;
			cuPkg::dpImm1:
				nextState = cuPkg::dpImm2;
			cuPkg::dpImm2:
				nextState = cuPkg::fetch1;
			cuPkg::dpShift:
				nextState = cuPkg::fetch1;
			cuPkg::branchLink:
				nextState = cuPkg::branch1;
			cuPkg::branch1:
				nextState = cuPkg::branch2;
			cuPkg::branch2:
				nextState = cuPkg::fetch1;
			default:
				// unused codes recover through the clear state
				nextState = cuPkg::reset;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!rstN)
		begin
			state <= cuPkg::reset;
		end
		else
		begin
			state <= nextState;
		end
	end

endmodule

//--- tb/controlUnitPatterns.mem
// columns: ir cond mocDelay steps word1 word2 word3
// words are the 31-bit control words after decode, unused ones zero
// data immediate
E3A01005 1 0 2 20067133 20400200 00000000
E3A01005 1 2 2 20067133 20400200 00000000
// data shifter
E0812003 1 0 1 20440800 00000000 00000000
E0812003 1 3 1 20440800 00000000 00000000
// branch, link bit clear
EA000004 1 0 2 20467793 2021C204 00000000
EB000004 1 1 2 20467793 2021C204 00000000
// branch with link
EA100010 1 0 3 20324204 20467793 2021C204
EA100010 1 2 3 20324204 20467793 2021C204
// condition false
E3A01005 0 1 0 00000000 00000000 00000000
EA100010 0 0 0 00000000 00000000 00000000
// load/store and reserved classes
E5912000 1 0 0 00000000 00000000 00000000
E7912003 1 2 0 00000000 00000000 00000000
EC000000 1 0 0 00000000 00000000 00000000

//--- tb/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb;

	localparam int numRecords = 13;
	localparam int recWords = 7;
	localparam int maxWait = 40;

	// shared fetch words, bit order follows ctrlWord_t from clear down to aluOp
	localparam logic [30:0] resetExp = 31'h4000_0000;
	localparam logic [30:0] fetch1Exp = 31'h0820_4010;
	localparam logic [30:0] fetch2Exp = 31'h2721_C011;
	localparam logic [30:0] fetchWaitExp = 31'h1700_0000;
	localparam logic [30:0] idleExp = 31'h0;

	logic CLK;
	logic rstN;
	logic [31:0] ir;
	logic cond;
	logic moc;
	cuPkg::ctrlWord_t ctrl;

	logic [31:0] patMem [0:numRecords*recWords-1];
	int seed;
	int errors;
	int timeouts;

	controlUnit u_dut
	(
		.CLK(CLK),
		.rstN(rstN),
		.ir(ir),
		.cond(cond),
		.moc(moc),
		.ctrl(ctrl)
	);

	initial
	begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	task automatic checkWord(input string name, input logic [30:0] expected,
		input logic [30:0] actual);
		if (actual !== expected)
		begin
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		if (actual != expected)
		begin
			$display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	// fetch1 is the only state with marLoad
	task automatic waitForFetch1();
		int n;
		n = 0;
		while (ctrl.marLoad !== 1'b1 && n < maxWait)
		begin
			@(negedge CLK);
			n++;
		end
		if (ctrl.marLoad !== 1'b1)
		begin
			$display("timeout waiting for fetch");
			timeouts++;
		end
	endtask

	// one instruction, entered and left at the negedge of a fetch1 cycle
	task automatic runInstr(input int idx);
		int base;
		int m;
		int k;
		int j;
		int n;
		int cycles;
		int irCycles;
		string name;
		base = idx * recWords;
		m = int'(patMem[base+2]) + ($random(seed) & 3);
		k = int'(patMem[base+3]);
		name = $sformatf("instr %0d", idx);
		checkWord({name, " fetch1"}, fetch1Exp, ctrl);
		ir = patMem[base];
		cond = patMem[base+1][0];
		moc = 1'b0;
		cycles = 0;
		n = 0;
		@(negedge CLK);
		cycles++;
		checkWord({name, " fetch2"}, fetch2Exp, ctrl);
		while (ctrl.irLoad !== 1'b1 && n < maxWait)
		begin
			@(negedge CLK);
			cycles++;
			n++;
		end
		if (ctrl.irLoad !== 1'b1)
		begin
			$display("timeout waiting for fetch");
			timeouts++;
			return;
		end
		irCycles = 0;
		n = 0;
		while (ctrl.irLoad === 1'b1 && n < maxWait)
		begin
			checkWord({name, " fetchWait"}, fetchWaitExp, ctrl);
			// moc is sampled at the edge that closes this cycle
			moc = (irCycles >= m);
			irCycles++;
			n++;
			@(negedge CLK);
			cycles++;
		end
		moc = 1'b0;
		if (ctrl.irLoad === 1'b1)
		begin
			$display("timeout waiting for fetch");
			timeouts++;
			return;
		end
		checkCount({name, " irLoad cycles"}, m + 1, irCycles);
		checkWord({name, " decode"}, idleExp, ctrl);
		for (j = 0; j < k; j++)
		begin
			@(negedge CLK);
			cycles++;
			checkWord($sformatf("%s step %0d", name, j + 1), patMem[base+4+j][30:0], ctrl);
		end
		@(negedge CLK);
		cycles++;
		checkWord({name, " next fetch1"}, fetch1Exp, ctrl);
		checkCount({name, " cycle count"}, 4 + m + k, cycles);
	endtask

	initial
	begin
		int i;
		seed = 32'h22fc15d3;
		errors = 0;
		timeouts = 0;
		rstN = 1'b0;
		ir = '0;
		cond = 1'b0;
		moc = 1'b0;
		$readmemh("tb/controlUnitPatterns.mem", patMem);
		for (i = 0; i < 5; i++)
		begin
			@(negedge CLK);
			checkWord("reset", resetExp, ctrl);
		end
		rstN = 1'b1;
		@(negedge CLK);
		checkWord("reset release", fetch1Exp, ctrl);
		for (i = 0; i < numRecords && timeouts == 0; i++)
		begin
			waitForFetch1();
			if (timeouts == 0)
			begin
				runInstr(i);
			end
		end
		$display("closing summary: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
		begin
			$display("Verification passed");
		end
		else
		begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- tb/controlUnit_properties.sv
`timescale 1ns/1ps

module controlUnitProperties
(
	input logic CLK,
	input logic rstN,
	input logic moc,
	input cuPkg::ctrlWord_t ctrl
);

	logic pastValid;

	initial
	begin
		pastValid = 1'b0;
	end

	always @(posedge CLK)
	begin
		pastValid <= 1'b1;
	end

	// clear only in the cycle that follows an edge with reset held
	clearAfterReset: assert property (@(posedge CLK)
		pastValid && ctrl.clear |-> !$past(rstN))
		else $error("clear asserted without a reset edge before it");

	irLoadReads: assert property (@(posedge CLK)
		ctrl.irLoad |-> ctrl.memEnable && ctrl.memReadWrite)
		else $error("irLoad without a memory read");

	// fetch wait holds while memory is busy
	irLoadHolds: assert property (@(posedge CLK) disable iff (!rstN)
		ctrl.irLoad && !moc |=> ctrl.irLoad)
		else $error("irLoad dropped before moc");

endmodule

bind controlUnit controlUnitProperties u_props
(
	.CLK(CLK),
	.rstN(rstN),
	.moc(moc),
	.ctrl(ctrl)
);

//--- verilog/controlUnit.sv
`timescale 1ns/1ps

module controlUnit
(
	input logic CLK,
	input logic rstN,
	input logic [cuPkg::irWidth-1:0] ir,
	input logic cond,
	input logic moc,
	output cuPkg::ctrlWord_t ctrl
);

	cuPkg::decodedInstr_t decoded;
	cuPkg::stateCode_t state;

	// ir is classified without a clock, the sequencer samples the flags at decode
	instrDecoder u_instrDecoder
	(
		.ir(ir),
		.decoded(decoded)
	);

	nextStateLogic u_nextStateLogic
	(
		.CLK(CLK),
		.rstN(rstN),
		.cond(cond),
		.moc(moc),
		.decoded(decoded),
		.state(state)
	);

	// Moore output, the control word depends on the state alone
	microcodeRom u_microcodeRom
	(
		.state(state),
		.ctrl(ctrl)
	);

endmodule

//--- verilog/microcodeRom.sv
`timescale 1ns/1ps

module microcodeRom
(
	input cuPkg::stateCode_t state,
	output cuPkg::ctrlWord_t ctrl
);

	always_comb
	begin
		ctrl = cuPkg::idleWord;
		case (state)
			cuPkg::reset:
			begin
				ctrl = cuPkg::resetWord;
			end
			cuPkg::fetch1:
			begin
				// MAR <- PC
				ctrl.marLoad = 1'b1;
				ctrl.sel.muxA = 2'd2;
				ctrl.sel.muxD = 1'b1;
				ctrl.aluOp = cuPkg::aluPass;
			end
			cuPkg::fetch2:
			begin
				// start the word read and advance PC
				ctrl.regFileLoad = 1'b1;
				ctrl.memReadWrite = 1'b1;
				ctrl.memEnable = 1'b1;
				ctrl.memSize = cuPkg::memSizeWord;
				ctrl.sel.muxA = 2'd2;
				ctrl.sel.muxC = 3'd3;
				ctrl.sel.muxD = 1'b1;
				ctrl.aluOp = cuPkg::aluPassInc;
			end
			cuPkg::fetchWait:
			begin
				// IR captures memory data, repeated while moc is low
				ctrl.irLoad = 1'b1;
				ctrl.memReadWrite = 1'b1;
				ctrl.memEnable = 1'b1;
				ctrl.memSize = cuPkg::memSizeWord;
			end
			cuPkg::dpImm1:
			begin
				ctrl.regFileLoad = 1'b1;
				ctrl.sel.muxB = 2'd1;
				ctrl.sel.muxC = 3'd4;
				ctrl.sel.muxD = 1'b1;
				ctrl.sel.muxF = 2'd3;
				ctrl.shiftEnable = 1'b1;
				ctrl.shiftType = cuPkg::shiftRotImm;
				ctrl.aluOp = cuPkg::aluAdd;
			end
			cuPkg::dpImm2:
			begin
				ctrl.regFileLoad = 1'b1;
				ctrl.flagLoad = 1'b1;
				ctrl.sel.muxJ = 2'd1;
			end
			cuPkg::dpShift:
			begin
				ctrl.regFileLoad = 1'b1;
				ctrl.flagLoad = 1'b1;
				ctrl.sel.muxB = 2'd1;
				ctrl.sel.muxH = 1'b1;
			end
			cuPkg::branch1:
			begin
				// PC + shifted offset
				ctrl.regFileLoad = 1'b1;
				ctrl.flagLoad = 1'b1;
				ctrl.sel.muxB = 2'd1;
				ctrl.sel.muxC = 3'd4;
				ctrl.sel.muxD = 1'b1;
				ctrl.sel.muxF = 2'd3;
				ctrl.sel.muxJ = 2'd3;
				ctrl.shiftEnable = 1'b1;
				ctrl.shiftType = cuPkg::shiftBranchOff;
				ctrl.aluOp = cuPkg::aluAdd;
			end
			cuPkg::branch2:
			begin
				ctrl.regFileLoad = 1'b1;
				ctrl.sel.muxA = 2'd2;
				ctrl.sel.muxC = 3'd3;
				ctrl.sel.muxD = 1'b1;
				ctrl.sel.muxJ = 2'd1;
				ctrl.aluOp = cuPkg::aluMovB;
			end
			cuPkg::branchLink:
			begin
				// LR <- PC before the branch steps
				ctrl.regFileLoad = 1'b1;
				ctrl.sel.muxA = 2'd3;
				ctrl.sel.muxC = 3'd4;
				ctrl.sel.muxD = 1'b1;
				ctrl.sel.muxJ = 2'd1;
				ctrl.aluOp = cuPkg::aluMovB;
			end
			default:
			begin
				// decode and unused codes drive no strobe
				ctrl = cuPkg::idleWord;
			end
		endcase
	end

endmodule
